// File: sources.f
design/up_pkg.sv
design/up_reg_block.sv
design/up_alu.sv
design/up_decode.sv
design/up_control.sv
design/up_core.sv
testbench/up_model.sv
testbench/up_tb.sv

// File: Bender.yml
package:
  name: up_core

sources:
  - design/up_pkg.sv
  - design/up_reg_block.sv
  - design/up_alu.sv
  - design/up_decode.sv
  - design/up_control.sv
  - design/up_core.sv
  - target: test
    files:
      - testbench/up_model.sv
      - testbench/up_tb.sv

// File: testbench/up_tb.sv
module up_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import up_pkg::*;

   localparam int unsigned SEED      = 32'hac2a_f527;
   localparam up_addr_t    DATA_BASE = 8'h80;

   logic        clk;
   logic        nRst;
   up_wb_req_t  wb_req;
   up_wb_rsp_t  wb_rsp;
   logic        halted;
   up_wb_req_t  held_req;
   logic        busy;
   logic        first_req;
   int unsigned wait_left;
   int unsigned cycles;
   int unsigned limit;
   int unsigned fetch_count;
   int unsigned store_count;
   int unsigned fetch_errs;
   int unsigned store_errs;
   int unsigned halt_errs;
   int unsigned hold_errs;
   int unsigned other_errs;

   up_core u_dut (
      .clk    (clk),
      .nRst   (nRst),
      .wb_rsp (wb_rsp),
      .wb_req (wb_req),
      .halted (halted)
   );

   up_model u_model ();

   task automatic check_fetch(string name, up_addr_t exp, up_addr_t act);
      if (exp !== act) begin
         fetch_errs++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_store(string name, up_wb_req_t exp, up_wb_req_t act);
      if (exp !== act) begin
         store_errs++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_hold(string name, up_wb_req_t exp, up_wb_req_t act);
      if (exp !== act) begin
         hold_errs++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_halt(string name, logic exp, logic act);
      if (exp !== act) begin
         halt_errs++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(string name, int unsigned exp, int unsigned act);
      if (exp != act) begin
         other_errs++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic raise_ack();
      wb_rsp.ack = 1'b1;
      if (held_req.we) begin
         wb_rsp.dat = '0;
      end else if (held_req.adr < DATA_BASE) begin
         wb_rsp.dat = u_model.prog[held_req.adr];
      end else begin
         wb_rsp.dat = {held_req.adr, u_model.data_mem[held_req.adr]};  // high byte is ignored.
      end
   endtask

   task automatic accept_request();
      up_wb_req_t exp;
      held_req  = wb_req;
      busy      = 1'b1;
      wait_left = $urandom_range(0, 3);
      check_halt("halted during run", 1'b0, halted);
      if (first_req) begin
         first_req = 1'b0;
         check_fetch("reset fetch", 8'h00, wb_req.adr);
         if (wb_req.we) begin
            other_errs++;
            $display("the first request after reset is a write instead of a fetch");
         end
      end
      if (wb_req.we) begin
         store_count++;
         if (u_model.exp_store_adr.size() == 0) begin
            other_errs++;
            $display("the core stores to %h but the program has no store left", wb_req.adr);
         end else begin
            exp     = '0;
            exp.cyc = 1'b1;
            exp.stb = 1'b1;
            exp.we  = 1'b1;
            exp.adr = u_model.exp_store_adr.pop_front();
            exp.dat = {8'h00, u_model.exp_store_dat.pop_front()};
            check_store("store", exp, wb_req);
         end
      end else if (wb_req.adr < DATA_BASE) begin
         fetch_count++;
         if (u_model.exp_fetch.size() == 0) begin
            other_errs++;
            $display("the core fetches from %h after the program ended", wb_req.adr);
         end else begin
            check_fetch("fetch", u_model.exp_fetch.pop_front(), wb_req.adr);
         end
      end
      if (wait_left == 0) begin
         raise_ack();
      end
   endtask

   task automatic print_report();
      int unsigned total;
      total = fetch_errs + store_errs + halt_errs + hold_errs + other_errs;
      $display("errors: fetch %0d, store %0d, halt %0d, hold %0d, other %0d",
               fetch_errs, store_errs, halt_errs, hold_errs, other_errs);
      if (total == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // the slave looks at the bus once per cycle, after the core has updated it.
   always begin
      @(posedge clk);
      #10;
      if (nRst) begin
         if (halted && wb_req.stb) begin
            other_errs++;
            $display("the core raised stb at %0t after it halted", $time);
         end
         if (wb_rsp.ack) begin
            wb_rsp = '0;
            busy   = 1'b0;
         end else if (busy) begin
            check_hold("held request", held_req, wb_req);
            wait_left--;
            if (wait_left == 0) begin
               raise_ack();
            end
         end else if (wb_req.stb) begin
            accept_request();
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         other_errs++;
         $display("the core did not halt within %0d cycles", limit);
         print_report();
         $finish;
      end
   end

   initial begin
      nRst        = 1'b0;
      wb_rsp      = '0;
      busy        = 1'b0;
      first_req   = 1'b1;
      wait_left   = 0;
      cycles      = 0;
      fetch_count = 0;
      store_count = 0;
      fetch_errs  = 0;
      store_errs  = 0;
      halt_errs   = 0;
      hold_errs   = 0;
      other_errs  = 0;
      void'($urandom(SEED));
      u_model.build_program();
      u_model.run_program();
      limit = u_model.prog_len * 12 + 50;
      repeat (5) @(posedge clk);
      #10;
      nRst = 1'b1;
      while (!halted) begin
         @(posedge clk);
         #10;
      end
      repeat (8) @(posedge clk);  // idle cycles in which no strobe may appear.
      #10;
      check_halt("halted at end", 1'b1, halted);
      check_count("fetch count", u_model.n_fetch, fetch_count);
      check_count("store count", u_model.n_store, store_count);
      print_report();
      $finish;
   end

endmodule

// File: testbench/up_model.sv
module up_model;
   timeunit 1ns;
   timeprecision 1ps;
   import up_pkg::*;

   localparam up_addr_t LOAD_BASE   = 8'h80;
   localparam up_addr_t STORE_BASE  = 8'hc0;
   localparam up_op_e   ALU_OPS [5] = '{ADD, SUB, AND, OR, XOR};

   logic [15:0] prog [256];  // words past the program read as nop.
   up_data_t    data_mem [256];
   int unsigned prog_len;
   int unsigned n_fetch;
   int unsigned n_store;
   up_addr_t    exp_fetch [$];
   up_addr_t    exp_store_adr [$];
   up_data_t    exp_store_dat [$];

   task automatic emit(logic [3:0] op, up_rsel_t rd, up_rsel_t rs, up_data_t imm);
      prog[prog_len] = {op, rd, rs, imm};
      prog_len++;
   endtask

   // a written register goes out to a store address so its value shows on the bus.
   task automatic expose(up_rsel_t r);
      emit(ST, 2'd0, r, up_data_t'(STORE_BASE + $urandom_range(0, 63)));
   endtask

   task automatic build_program();
      int unsigned target;
      up_rsel_t    rd;
      up_rsel_t    rs;
      up_instr_t   ins;
      prog_len = 0;
      foreach (prog[i]) begin
         prog[i]     = '0;
         data_mem[i] = up_data_t'($urandom);
      end
      target = $urandom_range(42, 60);
      while (prog_len + 3 < target) begin
         rd = up_rsel_t'($urandom_range(0, 3));
         rs = up_rsel_t'($urandom_range(0, 3));
         case ($urandom_range(0, 9))
            0: begin
               emit(LDI, rd, rs, up_data_t'($urandom));
               expose(rd);
            end
            1: begin
               emit(MOV, rd, rs, 8'h00);
               expose(rd);
            end
            2, 3, 4: begin
               emit(ALU_OPS[$urandom_range(0, 4)], rd, rs, 8'h00);
               expose(rd);
            end
            5: begin
               emit(SWAP, rd, rs, 8'h00);
               expose(rd);
               expose(rs);
            end
            6: begin
               emit(LD, rd, rs, up_data_t'(LOAD_BASE + $urandom_range(0, 63)));
               expose(rd);
            end
            7: emit(JMP, rd, rs, up_data_t'(prog_len + 1 + $urandom_range(0, 3)));
            8: begin
               if ($urandom_range(0, 1) == 1) begin
                  emit(XOR, rd, rd, 8'h00);  // a zero result makes the next jz taken.
                  expose(rd);
               end
               emit(JZ, rd, rs, up_data_t'(prog_len + 1 + $urandom_range(0, 3)));
            end
            default: begin
               if ($urandom_range(0, 1) == 1) begin
                  emit(4'hf, rd, rs, 8'h00);  // an unused opcode acts as a nop.
               end else begin
                  emit(NOP, rd, rs, 8'h00);
               end
            end
         endcase
      end
      emit(HALT, 2'd0, 2'd0, 8'h00);
      // jumps that point past the end land on the halt.
      for (int i = 0; i < prog_len; i++) begin
         ins = up_instr_t'(prog[i]);
         if ((ins.opcode == JMP || ins.opcode == JZ) && ins.imm >= prog_len) begin
            ins.imm = up_data_t'(prog_len - 1);
            prog[i] = ins;
         end
      end
   endtask

   task automatic run_program();
      up_data_t  regs [REG_COUNT];
      up_data_t  res;
      logic      zero;
      logic      done;
      up_addr_t  pc;
      up_instr_t ins;
      regs = REG_RESET;
      zero = 1'b0;
      done = 1'b0;
      pc   = PC_RESET;
      while (!done && exp_fetch.size() < 256) begin
         exp_fetch.push_back(pc);
         ins = up_instr_t'(prog[pc]);
         pc  = pc + 8'd1;
         case (ins.opcode)
            LDI: regs[ins.rd] = ins.imm;
            MOV: regs[ins.rd] = regs[ins.rs];
            ADD, SUB, AND, OR, XOR: begin
               case (ins.opcode)
                  ADD: res = regs[ins.rd] + regs[ins.rs];
                  SUB: res = regs[ins.rd] - regs[ins.rs];
                  AND: res = regs[ins.rd] & regs[ins.rs];
                  OR: res = regs[ins.rd] | regs[ins.rs];
                  default: res = regs[ins.rd] ^ regs[ins.rs];
               endcase
               regs[ins.rd] = res;
               zero         = (res == 8'h00);
            end
            SWAP: begin
               res          = regs[ins.rd];
               regs[ins.rd] = regs[ins.rs];
               regs[ins.rs] = res;  // same register on both sides stays as it was.
            end
            LD: regs[ins.rd] = data_mem[ins.imm];
            ST: begin
               exp_store_adr.push_back(ins.imm);
               exp_store_dat.push_back(regs[ins.rs]);
            end
            JMP: pc = ins.imm;
            JZ: if (zero) pc = ins.imm;
            HALT: done = 1'b1;
            default: ;
         endcase
      end
      n_fetch = exp_fetch.size();
      n_store = exp_store_adr.size();
   endtask

endmodule

// File: design/up_core.sv
module up_core (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::up_wb_rsp_t wb_rsp,
   output up_pkg::up_wb_req_t wb_req,
   output logic               halted
);
   import up_pkg::*;

   up_instr_t instr;
   up_ctrl_t  ctrl;
   up_data_t  rd_val;
   up_data_t  rs_val;
   up_data_t  alu_b;
   up_data_t  alu_result;
   up_data_t  load_data;
   up_data_t  wr_data_a;
   logic      we_a;
   logic      we_b;
   logic      load_sel;
   logic      zero;

   assign alu_b     = ctrl.src_imm ? instr.imm : rs_val;  // ldi feeds the immediate.
   assign wr_data_a = load_sel ? load_data : alu_result;

   up_control u_control (
      .clk        (clk),
      .nRst       (nRst),
      .wb_rsp     (wb_rsp),
      .zero       (zero),
      .store_data (rs_val),
      .ctrl       (ctrl),
      .wb_req     (wb_req),
      .instr      (instr),
      .we_a       (we_a),
      .we_b       (we_b),
      .load_data  (load_data),
      .load_sel   (load_sel),
      .halted     (halted)
   );

   up_decode u_decode (
      .instr (instr),
      .ctrl  (ctrl)
   );

   // on a swap port b takes the old rd value while port a takes rs.
   up_reg_block u_reg_block (
      .clk         (clk),
      .nRst        (nRst),
      .sel_out_a   (instr.rd),
      .sel_out_b   (instr.rs),
      .sel_write_a (ctrl.wsel_a),
      .sel_write_b (ctrl.wsel_b),
      .we_a        (we_a),
      .we_b        (we_b),
      .data_in_a   (wr_data_a),
      .data_in_b   (rd_val),
      .data_out_a  (rd_val),
      .data_out_b  (rs_val)
   );

   up_alu u_alu (
      .clk      (clk),
      .nRst     (nRst),
      .op       (ctrl.alu_op),
      .a        (rd_val),
      .b        (alu_b),
      .set_flag (ctrl.set_flag),
      .result   (alu_result),
      .zero     (zero)
   );

endmodule

// File: design/up_control.sv
module up_control (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::up_wb_rsp_t wb_rsp,
   input  logic               zero,
   input  up_pkg::up_data_t   store_data,
   input  up_pkg::up_ctrl_t   ctrl,
   output up_pkg::up_wb_req_t wb_req,
   output up_pkg::up_instr_t  instr,
   output logic               we_a,
   output logic               we_b,
   output up_pkg::up_data_t   load_data,
   output logic               load_sel,
   output logic               halted
);
   import up_pkg::*;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      MEM,
      HALTED
   } state_e;

   state_e    state;
   up_addr_t  pc;
   up_instr_t ir;
   logic      ack_seen;

   assign ack_seen = wb_req.stb && wb_rsp.ack;

   // decode sees a nop while fetching so no stale flag update can happen.
   assign instr = (state == EXEC || state == MEM) ? ir : '0;

   // loads write back on the ack edge and all other writes land at the end of exec.
   assign we_a = (state == EXEC && ctrl.we_a && !ctrl.mem_rd) ||
                 (state == MEM && ctrl.we_a && ack_seen);
   assign we_b = (state == EXEC) && ctrl.we_b;

   assign load_data = wb_rsp.dat[7:0];
   assign load_sel  = (state == MEM);

   always_ff @(posedge clk) begin
      if (state == FETCH && ack_seen) begin
         ir <= up_instr_t'(wb_rsp.dat);
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state  <= FETCH;
         pc     <= PC_RESET;
         wb_req <= '0;
         halted <= 1'b0;
      end else begin
         case (state)
            FETCH: begin
               if (!wb_req.cyc) begin
                  wb_req.cyc <= 1'b1;
                  wb_req.stb <= 1'b1;
                  wb_req.we  <= 1'b0;
                  wb_req.adr <= pc;
                  wb_req.dat <= '0;
               end else if (wb_rsp.ack) begin
                  wb_req.cyc <= 1'b0;
                  wb_req.stb <= 1'b0;
                  pc         <= pc + 8'd1;
                  state      <= EXEC;
               end
            end
            EXEC: begin
               if (ctrl.halt) begin
                  halted <= 1'b1;
                  state  <= HALTED;
               end else if (ctrl.mem_rd || ctrl.mem_wr) begin
                  wb_req.cyc <= 1'b1;
                  wb_req.stb <= 1'b1;
                  wb_req.we  <= ctrl.mem_wr;
                  wb_req.adr <= ir.imm;
                  wb_req.dat <= {8'h00, store_data};  // stores are zero extended.
                  state      <= MEM;
               end else begin
                  if (ctrl.jump || (ctrl.jump_zero && zero)) begin
                     pc <= ir.imm;
                  end
                  state <= FETCH;
               end
            end
            MEM: begin
               if (wb_rsp.ack) begin
                  wb_req.cyc <= 1'b0;
                  wb_req.stb <= 1'b0;
                  state      <= FETCH;
               end
            end
            default: begin
               state <= HALTED;  // nothing leaves this state.
            end
         endcase
      end
   end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!nRst)
      wb_req.stb |-> wb_req.cyc);

   // the request must not move while the slave stalls.
   a_req_stable: assert property (@(posedge clk) disable iff (!nRst)
      (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req));

   a_halt_final: assert property (@(posedge clk) disable iff (!nRst)
      (state == HALTED) |=> (state == HALTED) && !wb_req.stb);

endmodule

// File: design/up_decode.sv
module up_decode (
   input  up_pkg::up_instr_t instr,
   output up_pkg::up_ctrl_t  ctrl
);
   import up_pkg::*;

   always_comb begin
      ctrl        = '0;
      ctrl.wsel_a = instr.rd;
      ctrl.wsel_b = instr.rs;
      case (instr.opcode)
         LDI: begin
            ctrl.alu_op  = LDI;
            ctrl.we_a    = 1'b1;
            ctrl.src_imm = 1'b1;
         end
         MOV: begin
            ctrl.alu_op = MOV;
            ctrl.we_a   = 1'b1;
         end
         ADD, SUB, AND, OR, XOR: begin
            ctrl.alu_op   = instr.opcode;
            ctrl.we_a     = 1'b1;
            ctrl.set_flag = 1'b1;
         end
         SWAP: begin
            ctrl.alu_op = MOV;  // rs passes through to rd on port a.
            ctrl.we_a   = 1'b1;
            ctrl.we_b   = 1'b1;
         end
         LD: begin
            ctrl.we_a   = 1'b1;
            ctrl.mem_rd = 1'b1;
         end
         ST: begin
            ctrl.mem_wr = 1'b1;
         end
         JMP: begin
            ctrl.jump = 1'b1;
         end
         JZ: begin
            ctrl.jump_zero = 1'b1;
         end
         HALT: begin
            ctrl.halt = 1'b1;
         end
         default: begin
            ctrl.alu_op = NOP;  // unused codes behave like nop.
         end
      endcase
   end

endmodule

// File: design/up_alu.sv
module up_alu (
   input  logic             clk,
   input  logic             nRst,
   input  up_pkg::up_op_e   op,
   input  up_pkg::up_data_t a,
   input  up_pkg::up_data_t b,
   input  logic             set_flag,
   output up_pkg::up_data_t result,
   output logic             zero
);
   import up_pkg::*;

   always_comb begin
      case (op)
         LDI: begin
            result = b;  // the immediate arrives on b.
         end
         MOV: begin
            result = b;
         end
         ADD: begin
            result = a + b;  // carry out is dropped so the sum wraps.
         end
         SUB: begin
            result = a - b;
         end
         AND: begin
            result = a & b;
         end
         OR: begin
            result = a | b;
         end
         XOR: begin
            result = a ^ b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // flag holds until the next arithmetic or logic instruction.
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         zero <= 1'b0;
      end else if (set_flag) begin
         zero <= (result == '0);
      end
   end

endmodule

// File: design/up_reg_block.sv
module up_reg_block (
   input  logic             clk,
   input  logic             nRst,
   input  up_pkg::up_rsel_t sel_out_a,
   input  up_pkg::up_rsel_t sel_out_b,
   input  up_pkg::up_rsel_t sel_write_a,
   input  up_pkg::up_rsel_t sel_write_b,
   input  logic             we_a,
   input  logic             we_b,
   input  up_pkg::up_data_t data_in_a,
   input  up_pkg::up_data_t data_in_b,
   output up_pkg::up_data_t data_out_a,
   output up_pkg::up_data_t data_out_b
);
   import up_pkg::*;

   up_data_t regs [REG_COUNT];
   logic     write_b;

   // reads are plain muxes on the register array.
   assign data_out_a = regs[sel_out_a];
   assign data_out_b = regs[sel_out_b];

   // port b only lands when port a writes a different register.
   assign write_b = we_a && we_b && (sel_write_b != sel_write_a);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs <= REG_RESET;
      end else begin
         if (we_a) begin
            regs[sel_write_a] <= data_in_a;
         end
         if (write_b) begin
            regs[sel_write_b] <= data_in_b;
         end
      end
   end

   // the second port only ever rides along with the first.
   a_we_b_needs_a: assert property (@(posedge clk) disable iff (!nRst)
      we_b |-> we_a);

endmodule

// File: design/up_pkg.sv
package up_pkg;

   typedef logic [7:0] up_data_t;
   typedef logic [7:0] up_addr_t;
   typedef logic [1:0] up_rsel_t;

   localparam int unsigned REG_COUNT = 4;

   typedef enum logic [3:0] {
      NOP  = 4'h0,
      LDI  = 4'h1,
      MOV  = 4'h2,
      ADD  = 4'h3,
      SUB  = 4'h4,
      AND  = 4'h5,
      OR   = 4'h6,
      XOR  = 4'h7,
      SWAP = 4'h8,
      LD   = 4'h9,
      ST   = 4'ha,
      JMP  = 4'hb,
      JZ   = 4'hc,
      HALT = 4'hd
   } up_op_e;

   // one instruction word as fetched over the bus.
   typedef struct packed {
      up_op_e   opcode;
      up_rsel_t rd;
      up_rsel_t rs;
      up_data_t imm;
   } up_instr_t;

   typedef struct packed {
      up_op_e   alu_op;
      logic     we_a;
      logic     we_b;
      up_rsel_t wsel_a;
      up_rsel_t wsel_b;
      logic     src_imm;
      logic     mem_rd;
      logic     mem_wr;
      logic     jump;
      logic     jump_zero;
      logic     halt;
      logic     set_flag;
   } up_ctrl_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      up_addr_t    adr;
      logic [15:0] dat;
   } up_wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] dat;
   } up_wb_rsp_t;

   localparam up_data_t REG_RESET [REG_COUNT] = '{8'h01, 8'h02, 8'h03, 8'h04};
   localparam up_addr_t PC_RESET = 8'h00;

endpackage
